// ==== source/spi_apb_cfg.svh ====
// Register map and clock divider defaults of the APB SPI master

`ifndef SPI_APB_CFG_SVH
`define SPI_APB_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Register byte offsets
//////////////////////////////////////////////////////////////////////

// Divider, lane mode and interrupt enable
`define SPI_REG_CTRL    32'h0000_0000
// Write starts one byte transfer
`define SPI_REG_TXDATA  32'h0000_0004
// Last received byte, read clears done
`define SPI_REG_RXDATA  32'h0000_0008
// Bit 0 busy, bit 1 done
`define SPI_REG_STATUS  32'h0000_000C

//////////////////////////////////////////////////////////////////////
// Clock divider
//////////////////////////////////////////////////////////////////////

// Half sck period is divider + 1 clk cycles
`define SPI_DIV_W       8
`define SPI_DIV_RESET   3

`endif

// ==== source/spi_apb_pkg.sv ====
// Shared types of the SPI master: lane modes, command and response words

`include "spi_apb_cfg.svh"

package spi_apb_pkg;

	// How the dq lanes are used for one byte
	typedef enum logic [1:0] {
		LANE_SINGLE  = 2'd0,
		LANE_QUAD_TX = 2'd1,
		LANE_QUAD_RX = 2'd2
	} lane_mode_e;

	// One byte transfer request, 18 bits
	typedef struct packed {
		logic [7:0]            tx_byte;
		lane_mode_e            mode;
		logic [`SPI_DIV_W-1:0] div;
	} spi_cmd_t;

	// Byte collected from the lanes
	typedef struct packed {
		logic [7:0] rx_byte;
	} spi_rsp_t;

	// Output enables of dq3..dq0 for a lane mode
	function automatic logic [3:0] lane_oe(lane_mode_e mode);
		case (mode)
			LANE_QUAD_TX: lane_oe = 4'b1111;
			LANE_QUAD_RX: lane_oe = 4'b0000;
			default:      lane_oe = 4'b0001;
		endcase
	endfunction

	// Index of the final falling sck edge, 8 periods single or 2 quad
	function automatic logic [4:0] last_edge_idx(lane_mode_e mode);
		if (mode == LANE_QUAD_TX || mode == LANE_QUAD_RX)
			last_edge_idx = 5'd3;
		else
			last_edge_idx = 5'd15;
	endfunction

endpackage

// ==== source/apb_reg_bridge.sv ====
// APB register file that issues SPI commands, keeps the received byte and drives the interrupt

`timescale 1ns/1ps
`include "spi_apb_cfg.svh"

module apb_reg_bridge
	import spi_apb_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,
	output logic        cmd_req_o,
	input  logic        cmd_ack_i,
	output spi_cmd_t    cmd_o,
	input  logic        rsp_valid_i,
	input  spi_rsp_t    rsp_i,
	input  logic [1:0]  busy_i,
	output logic        interrupt_o
);

	logic [`SPI_DIV_W-1:0] div_q;
	lane_mode_e            mode_q;
	logic                  ien_q;
	logic                  done_q;
	logic                  cmd_req_q;
	logic [7:0]            rx_q;
	spi_cmd_t              cmd_q;
	logic                  access;
	logic                  sel_ctrl;
	logic                  sel_tx;
	logic                  sel_rx;
	logic                  sel_stat;
	logic                  addr_ok;
	logic                  tx_stall;
	logic                  acc_done;
	logic                  busy;

	assign access   = psel_i & penable_i;
	assign sel_ctrl = (paddr_i == `SPI_REG_CTRL);
	assign sel_tx   = (paddr_i == `SPI_REG_TXDATA);
	assign sel_rx   = (paddr_i == `SPI_REG_RXDATA);
	assign sel_stat = (paddr_i == `SPI_REG_STATUS);
	assign addr_ok  = sel_ctrl | sel_tx | sel_rx | sel_stat;

	// A new request waits until the previous handshake is fully closed
	assign tx_stall  = sel_tx & pwrite_i & (cmd_req_q | cmd_ack_i);
	assign pready_o  = access & ~tx_stall;
	assign pslverr_o = access & ~addr_ok;
	assign acc_done  = access & ~tx_stall & addr_ok;

	// Busy covers an open request, the slot entry and the shifting engine
	assign busy = cmd_req_q | (|busy_i);

	always_comb begin
		prdata_o = '0;
		if (sel_ctrl) begin
			prdata_o[`SPI_DIV_W-1:0] = div_q;
			prdata_o[9:8]            = mode_q;
			prdata_o[16]             = ien_q;
		end else if (sel_rx) begin
			prdata_o[7:0] = rx_q;
		end else if (sel_stat) begin
			prdata_o[1:0] = {done_q, busy};
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			div_q     <= `SPI_DIV_W'(`SPI_DIV_RESET);
			mode_q    <= LANE_SINGLE;
			ien_q     <= 1'b0;
			done_q    <= 1'b0;
			cmd_req_q <= 1'b0;
		end else begin
			if (cmd_req_q && cmd_ack_i)
				cmd_req_q <= 1'b0;
			if (acc_done && pwrite_i && sel_ctrl) begin
				div_q  <= pwdata_i[`SPI_DIV_W-1:0];
				mode_q <= lane_mode_e'(pwdata_i[9:8]);
				ien_q  <= pwdata_i[16];
			end
			if (acc_done && pwrite_i && sel_tx)
				cmd_req_q <= 1'b1;
			if (acc_done && !pwrite_i && sel_rx)
				done_q <= 1'b0;
			// A finishing transfer wins over a clearing read
			if (rsp_valid_i)
				done_q <= 1'b1;
		end
	end

	// Command word takes the CTRL settings at the time of the write
	always_ff @(posedge clk) begin
		if (acc_done && pwrite_i && sel_tx) begin
			cmd_q.tx_byte <= pwdata_i[7:0];
			cmd_q.mode    <= mode_q;
			cmd_q.div     <= div_q;
		end
		if (rsp_valid_i)
			rx_q <= rsp_i.rx_byte;
	end

	assign cmd_req_o   = cmd_req_q;
	assign cmd_o       = cmd_q;
	assign interrupt_o = done_q & ien_q;

	cmd_stable_a: assert property (@(posedge clk) disable iff (rst_i)
		cmd_req_o |=> (!cmd_req_o || $stable(cmd_o)))
		else $error("command payload changed during an open request");

endmodule

// ==== source/spi_cmd_slot.sv ====
// One-entry command stage with four-phase handshakes toward the bridge and the engine

`timescale 1ns/1ps

module spi_cmd_slot
	import spi_apb_pkg::*;
(
	input  logic     clk,
	input  logic     rst_i,
	input  logic     in_req_i,
	output logic     in_ack_o,
	input  spi_cmd_t in_cmd_i,
	output logic     out_req_o,
	input  logic     out_ack_i,
	output spi_cmd_t out_cmd_o,
	output logic     occupied_o
);

	typedef enum logic [1:0] {IN_IDLE, IN_LOAD, IN_ACK} in_state_e;
	typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT} out_state_e;

	in_state_e  in_st_q;
	out_state_e out_st_q;
	logic       full_q;
	spi_cmd_t   buf_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			in_st_q  <= IN_IDLE;
			out_st_q <= OUT_IDLE;
			full_q   <= 1'b0;
		end else begin
			// Input side
			case (in_st_q)
				IN_IDLE: if (in_req_i && !full_q) in_st_q <= IN_LOAD;
				IN_LOAD: begin
					full_q  <= 1'b1;
					in_st_q <= IN_ACK;
				end
				default: if (!in_req_i) in_st_q <= IN_IDLE;
			endcase
			// Output side frees the entry once the engine has it
			case (out_st_q)
				OUT_IDLE: if (full_q) out_st_q <= OUT_REQ;
				OUT_REQ: begin
					if (out_ack_i) begin
						full_q   <= 1'b0;
						out_st_q <= OUT_WAIT;
					end
				end
				default: if (!out_ack_i) out_st_q <= OUT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_st_q == IN_LOAD)
			buf_q <= in_cmd_i;
	end

	assign in_ack_o   = (in_st_q == IN_ACK);
	assign out_req_o  = (out_st_q == OUT_REQ);
	assign out_cmd_o  = buf_q;
	assign occupied_o = full_q | (in_st_q == IN_LOAD);

	req_after_ack_low_a: assert property (@(posedge clk) disable iff (rst_i)
		$rose(out_req_o) |-> !out_ack_i)
		else $error("engine request raised before the previous ack fell");

endmodule

// ==== source/spi_shift_engine.sv ====
// SPI mode 0 shift engine: sck and chip select generation, single and quad lane shifting

`timescale 1ns/1ps
`include "spi_apb_cfg.svh"

module spi_shift_engine
	import spi_apb_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  logic       cmd_req_i,
	output logic       cmd_ack_o,
	input  spi_cmd_t   cmd_i,
	output logic       rsp_valid_o,
	output spi_rsp_t   rsp_o,
	output logic       active_o,
	output logic       spi_clk_o,
	output logic       spi_cs_o,
	input  logic [3:0] dq_i,
	output logic [3:0] dq_o,
	output logic [3:0] dq_oe_o
);

	logic                  cs_q;
	logic                  sck_q;
	logic                  ack_q;
	logic                  rsp_valid_q;
	logic [`SPI_DIV_W-1:0] half_cnt_q;
	logic [4:0]            edge_cnt_q;
	logic [`SPI_DIV_W-1:0] div_q;
	lane_mode_e            mode_q;
	logic [7:0]            tx_q;
	logic [7:0]            rx_q;
	spi_rsp_t              rsp_q;
	logic                  start;
	logic                  tick;
	logic                  last_edge;
	logic                  quad;

	// New command only when idle and the last handshake has closed
	assign start     = cs_q & cmd_req_i & ~ack_q;
	assign tick      = ~cs_q & (half_cnt_q == div_q);
	assign last_edge = (edge_cnt_q == last_edge_idx(mode_q));
	assign quad      = (mode_q == LANE_QUAD_TX) | (mode_q == LANE_QUAD_RX);

	//////////////////////////////////////////////////////////////////////
	// Control: handshake, half period counter, sck and chip select
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cs_q        <= 1'b1;
			sck_q       <= 1'b0;
			ack_q       <= 1'b0;
			rsp_valid_q <= 1'b0;
			half_cnt_q  <= '0;
			edge_cnt_q  <= '0;
		end else begin
			rsp_valid_q <= 1'b0;
			if (ack_q && !cmd_req_i)
				ack_q <= 1'b0;
			if (start) begin
				ack_q      <= 1'b1;
				cs_q       <= 1'b0;
				half_cnt_q <= '0;
				edge_cnt_q <= '0;
			end else if (!cs_q) begin
				if (tick) begin
					half_cnt_q <= '0;
					edge_cnt_q <= edge_cnt_q + 5'd1;
					sck_q      <= ~sck_q;
					// Last falling edge ends the byte and releases cs
					if (sck_q && last_edge) begin
						cs_q        <= 1'b1;
						rsp_valid_q <= 1'b1;
					end
				end else begin
					half_cnt_q <= half_cnt_q + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data path, MSB first
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start) begin
			tx_q   <= cmd_i.tx_byte;
			mode_q <= cmd_i.mode;
			div_q  <= cmd_i.div;
		end else if (tick) begin
			if (!sck_q) begin
				// Rising sck samples
				rx_q <= quad ? {rx_q[3:0], dq_i} : {rx_q[6:0], dq_i[1]};
			end else begin
				// Falling sck shifts the next bits out
				tx_q <= quad ? {tx_q[3:0], 4'h0} : {tx_q[6:0], 1'b0};
				if (last_edge)
					rsp_q.rx_byte <= rx_q;
			end
		end
	end

	assign dq_o        = quad ? tx_q[7:4] : {3'b000, tx_q[7]};
	assign dq_oe_o     = cs_q ? 4'b0000 : lane_oe(mode_q);
	assign spi_clk_o   = sck_q;
	assign spi_cs_o    = cs_q;
	assign active_o    = ~cs_q;
	assign cmd_ack_o   = ack_q;
	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

	sck_inside_cs_a: assert property (@(posedge clk) disable iff (rst_i)
		$changed(spi_clk_o) |-> !$past(spi_cs_o))
		else $error("sck toggled while chip select was high");

endmodule

// ==== source/spi_apb_top.sv ====
// APB SPI master top level joining the register bridge, the command slot and the shift engine

`timescale 1ns/1ps

module spi_apb_top
	import spi_apb_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,
	output logic        spi_clk_o,
	output logic        spi_cs_o,
	input  logic [3:0]  dq_i,
	output logic [3:0]  dq_o,
	output logic [3:0]  dq_oe_o,
	output logic        interrupt_o
);

	// Bridge to slot
	logic     cmd_req;
	logic     cmd_ack;
	spi_cmd_t cmd;
	// Slot to engine
	logic     eng_req;
	logic     eng_ack;
	spi_cmd_t eng_cmd;
	// Engine back to bridge
	logic     rsp_valid;
	spi_rsp_t rsp;
	logic     occupied;
	logic     active;

	apb_reg_bridge apb_reg_bridge_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.cmd_req_o   (cmd_req),
		.cmd_ack_i   (cmd_ack),
		.cmd_o       (cmd),
		.rsp_valid_i (rsp_valid),
		.rsp_i       (rsp),
		.busy_i      ({active, occupied}),
		.interrupt_o (interrupt_o)
	);

	spi_cmd_slot spi_cmd_slot_inst (
		.clk        (clk),
		.rst_i      (rst_i),
		.in_req_i   (cmd_req),
		.in_ack_o   (cmd_ack),
		.in_cmd_i   (cmd),
		.out_req_o  (eng_req),
		.out_ack_i  (eng_ack),
		.out_cmd_o  (eng_cmd),
		.occupied_o (occupied)
	);

	spi_shift_engine spi_shift_engine_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.cmd_req_i   (eng_req),
		.cmd_ack_o   (eng_ack),
		.cmd_i       (eng_cmd),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp),
		.active_o    (active),
		.spi_clk_o   (spi_clk_o),
		.spi_cs_o    (spi_cs_o),
		.dq_i        (dq_i),
		.dq_o        (dq_o),
		.dq_oe_o     (dq_oe_o)
	);

endmodule

// ==== verif/spi_flash_model.sv ====
// Pin-level SPI slave model that logs bytes from the master and returns a preset reply

`timescale 1ns/1ps

module spi_flash_model (
	input  logic       spi_clk_i,
	input  logic       spi_cs_i,
	input  logic [3:0] dq_i,
	input  logic [3:0] dq_oe_i,
	input  logic [7:0] reply_i,
	output logic [3:0] dq_o
);

	logic [7:0] out_shift;
	logic [7:0] in_shift;
	logic       quad_tx;
	logic       quad_rx;
	int         beats;
	logic [7:0] rx_log [0:15];
	logic [4:0] rx_count;

	// Reply lanes: all four in quad receive, dq1 otherwise
	function automatic logic [3:0] lane_drive(input logic [7:0] value, input logic nibble);
		lane_drive = nibble ? value[7:4] : {2'b00, value[7], 1'b0};
	endfunction

	initial begin
		dq_o      = 4'h0;
		rx_count  = 5'd0;
		in_shift  = 8'h00;
		out_shift = 8'h00;
		forever begin
			@(negedge spi_cs_i);
			// Lane use is read from the master's output enables once they settle
			#1;
			quad_tx   = (dq_oe_i == 4'b1111);
			quad_rx   = (dq_oe_i == 4'b0000);
			beats     = (quad_tx || quad_rx) ? 2 : 8;
			out_shift = reply_i;
			dq_o      = lane_drive(out_shift, quad_rx);
			for (int i = 0; i < beats; i++) begin
				@(posedge spi_clk_i);
				if (beats == 2)
					in_shift = {in_shift[3:0], dq_i};
				else
					in_shift = {in_shift[6:0], dq_i[0]};
				@(negedge spi_clk_i);
				out_shift = (beats == 2) ? {out_shift[3:0], 4'h0} : {out_shift[6:0], 1'b0};
				dq_o      = lane_drive(out_shift, quad_rx);
			end
			// Nothing arrives from the master in quad receive
			if (!quad_rx && rx_count < 5'd16) begin
				rx_log[rx_count[3:0]] = in_shift;
				rx_count = rx_count + 5'd1;
			end
		end
	end

endmodule

// ==== verif/spi_apb_tb.sv ====
// Directed testbench of the APB SPI master against a pin-level flash model

`timescale 1ns/1ps
`include "spi_apb_cfg.svh"

module spi_apb_tb
	import spi_apb_pkg::*;
();

	// Cycle limit far above the length of all directed tests
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        spi_clk;
	logic        spi_cs;
	logic [3:0]  dq_mosi;
	logic [3:0]  dq_miso;
	logic [3:0]  dq_oe;
	logic        irq;
	logic [7:0]  reply_byte;

	int          error_count;
	int          check_count;
	int          cycle_count;
	string       test_name;
	logic        oe_watch;
	logic [3:0]  oe_expect;
	logic [3:0]  oe_now;
	logic        irq_forbid;

	spi_apb_top spi_apb_top_inst (
		.clk         (clk),
		.rst_i       (rst),
		.psel_i      (psel),
		.penable_i   (penable),
		.pwrite_i    (pwrite),
		.paddr_i     (paddr),
		.pwdata_i    (pwdata),
		.prdata_o    (prdata),
		.pready_o    (pready),
		.pslverr_o   (pslverr),
		.spi_clk_o   (spi_clk),
		.spi_cs_o    (spi_cs),
		.dq_i        (dq_miso),
		.dq_o        (dq_mosi),
		.dq_oe_o     (dq_oe),
		.interrupt_o (irq)
	);

	spi_flash_model spi_flash_model_inst (
		.spi_clk_i (spi_clk),
		.spi_cs_i  (spi_cs),
		.dq_i      (dq_mosi),
		.dq_oe_i   (dq_oe),
		.reply_i   (reply_byte),
		.dq_o      (dq_miso)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Checking and APB access
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual == expected)
		else begin
			error_count++;
			$display("Mismatch in %s: %s expected %0h actual %0h", test_name, what,
				expected, actual);
		end
	endtask

	// Setup phase then access phase until pready
	// Outputs are sampled at the falling clock edge
	task automatic bus_access(input logic write, input logic [31:0] addr,
			input logic [31:0] data, output logic [31:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rdata;
		bus_access(1'b1, addr, data, unused_rdata, err);
	endtask

	task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
		bus_access(1'b0, addr, 32'h0, rdata, err);
	endtask

	task automatic set_ctrl(input logic [7:0] div, input lane_mode_e mode, input logic ien);
		logic err;
		apb_write(`SPI_REG_CTRL, {15'h0, ien, 6'h0, mode, div}, err);
	endtask

	// Poll until done is set and nothing is left in flight
	task automatic wait_done();
		logic [31:0] status;
		logic        err;
		status = 32'h0;
		while (!(status[1] && !status[0]))
			apb_read(`SPI_REG_STATUS, status, err);
	endtask

	task automatic transfer(input logic [7:0] tx, input logic [7:0] reply, output logic [7:0] rx);
		logic [31:0] rdata;
		logic        err;
		reply_byte = reply;
		apb_write(`SPI_REG_TXDATA, {24'h0, tx}, err);
		check_value("TXDATA pslverr", 32'h0, 32'(err));
		wait_done();
		apb_read(`SPI_REG_RXDATA, rdata, err);
		rx = rdata[7:0];
	endtask

	task automatic check_captured(input int index, input logic [7:0] expected);
		check_count++;
		assert (index < int'(spi_flash_model_inst.rx_count))
		else begin
			error_count++;
			$display("Flash model logged no byte at position %0d in %s", index, test_name);
		end
		if (index < int'(spi_flash_model_inst.rx_count))
			check_value("captured byte", 32'(expected),
				32'(spi_flash_model_inst.rx_log[index[3:0]]));
	endtask

	// Lane enables and the interrupt are watched while a test runs
	always @(negedge clk) begin
		if (oe_watch) begin
			oe_now = spi_cs ? 4'b0000 : oe_expect;
			check_value("dq_oe", 32'(oe_now), 32'(dq_oe));
		end
		if (irq_forbid)
			check_value("interrupt_o", 32'h0, 32'(irq));
	end

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_values();
		logic [31:0] rdata;
		logic        err;
		test_name = "reset values";
		apb_read(`SPI_REG_CTRL, rdata, err);
		check_value("CTRL", 32'(`SPI_DIV_RESET), rdata);
		apb_read(`SPI_REG_STATUS, rdata, err);
		check_value("STATUS", 32'h0, rdata);
		check_value("spi_cs", 32'h1, 32'(spi_cs));
		check_value("spi_clk", 32'h0, 32'(spi_clk));
		check_value("dq_oe", 32'h0, 32'(dq_oe));
		check_value("interrupt_o", 32'h0, 32'(irq));
	endtask

	task automatic test_single(input logic [7:0] div);
		logic [7:0] tx;
		logic [7:0] reply;
		logic [7:0] rx;
		int         base;
		test_name = $sformatf("single mode div %0d", div);
		tx        = 8'($urandom);
		reply     = 8'($urandom);
		base      = int'(spi_flash_model_inst.rx_count);
		set_ctrl(div, LANE_SINGLE, 1'b0);
		oe_expect = 4'b0001;
		oe_watch  = 1'b1;
		transfer(tx, reply, rx);
		oe_watch  = 1'b0;
		check_captured(base, tx);
		check_value("RXDATA", 32'(reply), 32'(rx));
	endtask

	task automatic test_quad();
		logic [7:0] tx;
		logic [7:0] reply;
		logic [7:0] rx;
		int         base;
		test_name = "quad transmit";
		tx        = 8'($urandom);
		base      = int'(spi_flash_model_inst.rx_count);
		set_ctrl(8'd1, LANE_QUAD_TX, 1'b0);
		oe_expect = 4'b1111;
		oe_watch  = 1'b1;
		transfer(tx, 8'h00, rx);
		oe_watch  = 1'b0;
		check_captured(base, tx);
		test_name = "quad receive";
		reply     = 8'($urandom);
		set_ctrl(8'd2, LANE_QUAD_RX, 1'b0);
		oe_expect = 4'b0000;
		oe_watch  = 1'b1;
		transfer(8'h5a, reply, rx);
		oe_watch  = 1'b0;
		check_value("RXDATA", 32'(reply), 32'(rx));
	endtask

	task automatic test_back_to_back();
		logic [7:0]  tx0;
		logic [7:0]  tx1;
		logic [31:0] rdata;
		logic        err;
		int          base;
		test_name  = "back to back";
		tx0        = 8'($urandom);
		tx1        = 8'($urandom);
		reply_byte = 8'($urandom);
		base       = int'(spi_flash_model_inst.rx_count);
		set_ctrl(8'd1, LANE_SINGLE, 1'b0);
		apb_write(`SPI_REG_TXDATA, {24'h0, tx0}, err);
		check_value("first write pslverr", 32'h0, 32'(err));
		// Second write stalls on the open request until the slot takes it
		apb_write(`SPI_REG_TXDATA, {24'h0, tx1}, err);
		check_value("second write pslverr", 32'h0, 32'(err));
		wait_done();
		apb_read(`SPI_REG_RXDATA, rdata, err);
		check_value("RXDATA", 32'(reply_byte), rdata);
		check_captured(base, tx0);
		check_captured(base + 1, tx1);
	endtask

	task automatic test_interrupt(input logic enable);
		logic [31:0] rdata;
		logic        err;
		test_name  = enable ? "interrupt enabled" : "interrupt disabled";
		irq_forbid = !enable;
		reply_byte = 8'($urandom);
		set_ctrl(8'd0, LANE_SINGLE, enable);
		apb_write(`SPI_REG_TXDATA, 32'h0000_00c3, err);
		check_value("interrupt before done", 32'h0, 32'(irq));
		wait_done();
		check_value("interrupt after done", 32'(enable), 32'(irq));
		apb_read(`SPI_REG_RXDATA, rdata, err);
		check_value("interrupt after RXDATA read", 32'h0, 32'(irq));
		irq_forbid = 1'b0;
	endtask

	task automatic test_bad_offset();
		logic [31:0] ctrl_expect;
		logic [31:0] rdata;
		logic        err;
		test_name   = "bad offset";
		// Divider 5 with quad transmit and the interrupt enabled
		ctrl_expect = 32'h0001_0105;
		set_ctrl(8'd5, LANE_QUAD_TX, 1'b1);
		apb_write(32'h0000_0010, 32'hffff_ffff, err);
		check_value("write pslverr", 32'h1, 32'(err));
		apb_read(32'h0000_0010, rdata, err);
		check_value("read pslverr", 32'h1, 32'(err));
		apb_read(`SPI_REG_CTRL, rdata, err);
		check_value("CTRL after bad access", ctrl_expect, rdata);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst         = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = 32'h0;
		pwdata      = 32'h0;
		reply_byte  = 8'h00;
		error_count = 0;
		check_count = 0;
		oe_watch    = 1'b0;
		oe_expect   = 4'h0;
		irq_forbid  = 1'b0;
		test_name   = "setup";
		void'($urandom(32'h38e5));
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset_values();
		test_single(8'd0);
		test_single(8'd3);
		test_quad();
		test_back_to_back();
		test_interrupt(1'b1);
		test_interrupt(1'b0);
		test_bad_offset();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== spi_apb.f ====
+incdir+source
source/spi_apb_pkg.sv
source/apb_reg_bridge.sv
source/spi_cmd_slot.sv
source/spi_shift_engine.sv
source/spi_apb_top.sv
verif/spi_flash_model.sv
verif/spi_apb_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = spi_apb_tb
FILELIST  = spi_apb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
